//--- hw/irq_pkg.sv
package irq_pkg;

    // number of interrupt sources handled by the controller
    localparam int NUM_SRC = 16;

    // width of a source index
    localparam int ID_W = 4;

    // selector FSM states
    typedef enum logic {
        // nothing presented to the cpu
        SEL_IDLE   = 1'b0,
        // one interrupt presented, waiting for ack
        SEL_ACTIVE = 1'b1
    } sel_state_e;

endpackage

//--- hw/irq_cfg_pkg.sv
package irq_cfg_pkg;

    // width of the configuration opcode
    localparam int CFG_OP_W = 3;

    // configuration opcodes acting on the source named by cfg_idx
    typedef enum logic [CFG_OP_W-1:0] {
        CFG_NOP        = 3'd0,
        // block the source
        CFG_SET_MASK   = 3'd1,
        // unblock the source
        CFG_CLR_MASK   = 3'd2,
        // class bit to 1
        CFG_SET_URGENT = 3'd3,
        // class bit to 0
        CFG_SET_NORMAL = 3'd4
    } cfg_op_e;

endpackage

//--- hw/irq_pend_if.sv
`timescale 1ns/100ps

interface irq_pend_if;

    // unmasked pending bits of urgent class sources
    logic [irq_pkg::NUM_SRC-1:0] urgent_req;
    // unmasked pending bits of normal class sources
    logic [irq_pkg::NUM_SRC-1:0] normal_req;

    // acknowledge strobe from the selector
    logic                        ack_stb;
    // one-hot of the pending bit to clear
    logic [irq_pkg::NUM_SRC-1:0] ack_onehot;

    // pending block side
    modport pend (
        output urgent_req,
        output normal_req,
        input  ack_stb,
        input  ack_onehot
    );

    // selector side drives only the clear path
    modport sel (
        output ack_stb,
        output ack_onehot
    );

endinterface

//--- hw/priority_encoder.sv
`timescale 1ns/100ps

module priority_encoder #(
    parameter int WIDTH             = 4,
    // nonzero makes bit 0 the winner over higher bits
    parameter int LSB_HIGH_PRIORITY = 0
) (
    input  logic [WIDTH-1:0]         input_unencoded,
    output logic                     output_valid,
    output logic [$clog2(WIDTH)-1:0] output_encoded,
    output logic [WIDTH-1:0]         output_unencoded
);

    // tree depth and padded leaf count
    localparam int LEVELS = (WIDTH > 2) ? $clog2(WIDTH) : 1;
    localparam int W      = 2 ** LEVELS;

    // leaves extended with zeros up to a power of two
    logic [W-1:0] padded;

    // per level node state with the leaves at level 0
    logic              node_valid [LEVELS+1][W];
    logic [LEVELS-1:0] node_idx   [LEVELS+1][W];

    assign padded = W'(input_unencoded);

    // leaves carry their own request and a zero partial index
    for (genvar i = 0; i < W; i++) begin : g_leaf
        assign node_valid[0][i] = padded[i];
        assign node_idx[0][i]   = '0;
    end

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        // each node merges two children of the level below
        for (genvar n = 0; n < (W >> (l + 1)); n++) begin : g_node
            logic take_hi;

            if (LSB_HIGH_PRIORITY != 0) begin : g_lsb
                // upper child only wins when the lower one is empty
                assign take_hi = !node_valid[l][2*n];
            end else begin : g_msb
                // upper child wins whenever it requests
                assign take_hi = node_valid[l][2*n+1];
            end

            assign node_valid[l+1][n] = node_valid[l][2*n] | node_valid[l][2*n+1];
            // bit l of the index says which child won
            assign node_idx[l+1][n] = take_hi ?
                                      (node_idx[l][2*n+1] | (LEVELS'(1) << l)) :
                                      node_idx[l][2*n];
        end

        // upper half of each level has no node and is tied off
        for (genvar n = (W >> (l + 1)); n < W; n++) begin : g_unused
            assign node_valid[l+1][n] = 1'b0;
            assign node_idx[l+1][n]   = '0;
        end
    end

    // root of the tree
    assign output_valid   = node_valid[LEVELS][0];
    assign output_encoded = node_idx[LEVELS][0];

    // one-hot is empty when nothing requests
    assign output_unencoded = output_valid ? (WIDTH'(1) << output_encoded) : '0;

endmodule

//--- hw/irq_pending.sv
`timescale 1ns/100ps

module irq_pending (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [irq_pkg::NUM_SRC-1:0] src,
    input  irq_cfg_pkg::cfg_op_e        cfg_op,
    input  logic [irq_pkg::ID_W-1:0]    cfg_idx,
    irq_pend_if.pend                    pend
);

    // previous source levels for edge detection
    logic [irq_pkg::NUM_SRC-1:0] src_q;
    logic [irq_pkg::NUM_SRC-1:0] pending;
    logic [irq_pkg::NUM_SRC-1:0] mask;
    // 1 marks an urgent source
    logic [irq_pkg::NUM_SRC-1:0] cls;

    logic [irq_pkg::NUM_SRC-1:0] edge_set;
    logic [irq_pkg::NUM_SRC-1:0] pending_nxt;
    logic [irq_pkg::NUM_SRC-1:0] mask_nxt;
    logic [irq_pkg::NUM_SRC-1:0] cls_nxt;

    always_comb begin
        // rising edge seen on this clock
        edge_set = src & ~src_q;

        // clear first so that a fresh edge on the same bit wins
        pending_nxt = pending;
        if (pend.ack_stb) begin
            pending_nxt = pending_nxt & ~pend.ack_onehot;
        end
        pending_nxt = pending_nxt | edge_set;

        mask_nxt = mask;
        cls_nxt  = cls;
        case (cfg_op)
            irq_cfg_pkg::CFG_SET_MASK:   mask_nxt[cfg_idx] = 1'b1;
            irq_cfg_pkg::CFG_CLR_MASK:   mask_nxt[cfg_idx] = 1'b0;
            irq_cfg_pkg::CFG_SET_URGENT: cls_nxt[cfg_idx]  = 1'b1;
            irq_cfg_pkg::CFG_SET_NORMAL: cls_nxt[cfg_idx]  = 1'b0;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src_q           <= '0;
            pending         <= '0;
            mask            <= '0;
            cls             <= '0;
            pend.urgent_req <= '0;
            pend.normal_req <= '0;
        end else begin
            src_q   <= src;
            pending <= pending_nxt;
            mask    <= mask_nxt;
            cls     <= cls_nxt;
            // request vectors follow the new state right after this edge
            pend.urgent_req <= pending_nxt & ~mask_nxt & cls_nxt;
            pend.normal_req <= pending_nxt & ~mask_nxt & ~cls_nxt;
        end
    end

    // the selector must name exactly one source to clear
    a_ack_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        pend.ack_stb |-> $onehot(pend.ack_onehot)
    );

endmodule

//--- hw/irq_select.sv
`timescale 1ns/100ps

module irq_select (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        urg_valid,
    input  logic [irq_pkg::ID_W-1:0]    urg_id,
    input  logic [irq_pkg::NUM_SRC-1:0] urg_onehot,
    input  logic                        nrm_valid,
    input  logic [irq_pkg::ID_W-1:0]    nrm_id,
    input  logic [irq_pkg::NUM_SRC-1:0] nrm_onehot,
    input  logic                        ack,
    irq_pend_if.sel                     pend,
    output logic                        irq,
    output logic [irq_pkg::ID_W-1:0]    irq_id,
    output logic                        irq_urgent
);

    irq_pkg::sel_state_e state;

    // one-hot of the presented source, used to clear its pending bit
    logic [irq_pkg::NUM_SRC-1:0] act_onehot;
    // a new interrupt is taken on this edge
    logic                        take;

    assign take = (state == irq_pkg::SEL_IDLE) && (urg_valid || nrm_valid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= irq_pkg::SEL_IDLE;
            irq        <= 1'b0;
            irq_id     <= '0;
            irq_urgent <= 1'b0;
        end else begin
            case (state)
                irq_pkg::SEL_IDLE: begin
                    if (take) begin
                        state <= irq_pkg::SEL_ACTIVE;
                        irq   <= 1'b1;
                        // urgent class always beats normal
                        irq_id     <= urg_valid ? urg_id : nrm_id;
                        irq_urgent <= urg_valid;
                    end
                end
                irq_pkg::SEL_ACTIVE: begin
                    if (ack) begin
                        state <= irq_pkg::SEL_IDLE;
                        irq   <= 1'b0;
                    end
                end
                default: begin
                    state <= irq_pkg::SEL_IDLE;
                    irq   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            act_onehot <= urg_valid ? urg_onehot : nrm_onehot;
        end
    end

    // ack outside an active interrupt is dropped here
    assign pend.ack_stb    = ack && (state == irq_pkg::SEL_ACTIVE);
    assign pend.ack_onehot = act_onehot;

    // presented interrupt must not change under the cpu
    a_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == irq_pkg::SEL_ACTIVE && !ack) |=> ($stable(irq_id) && $stable(irq_urgent))
    );

    // registered irq never drifts away from the FSM state
    a_irq_state: assert property (
        @(posedge clk) disable iff (!arst_n)
        irq == (state == irq_pkg::SEL_ACTIVE)
    );

endmodule

//--- hw/irq_ctrl_top.sv
`timescale 1ns/100ps

module irq_ctrl_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [irq_pkg::NUM_SRC-1:0] src,
    input  irq_cfg_pkg::cfg_op_e        cfg_op,
    input  logic [irq_pkg::ID_W-1:0]    cfg_idx,
    input  logic                        ack,
    output logic                        irq,
    output logic [irq_pkg::ID_W-1:0]    irq_id,
    output logic                        irq_urgent
);

    // request and clear path between pending block and selector
    irq_pend_if pend_if ();

    // urgent encoder result
    logic                        urg_valid;
    logic [irq_pkg::ID_W-1:0]    urg_id;
    logic [irq_pkg::NUM_SRC-1:0] urg_onehot;

    // normal encoder result
    logic                        nrm_valid;
    logic [irq_pkg::ID_W-1:0]    nrm_id;
    logic [irq_pkg::NUM_SRC-1:0] nrm_onehot;

    irq_pending pend_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .src     (src),
        .cfg_op  (cfg_op),
        .cfg_idx (cfg_idx),
        .pend    (pend_if.pend)
    );

    // lowest index wins inside each class
    priority_encoder #(
        .WIDTH             (irq_pkg::NUM_SRC),
        .LSB_HIGH_PRIORITY (1)
    ) enc_urgent_i (
        .input_unencoded  (pend_if.urgent_req),
        .output_valid     (urg_valid),
        .output_encoded   (urg_id),
        .output_unencoded (urg_onehot)
    );

    priority_encoder #(
        .WIDTH             (irq_pkg::NUM_SRC),
        .LSB_HIGH_PRIORITY (1)
    ) enc_normal_i (
        .input_unencoded  (pend_if.normal_req),
        .output_valid     (nrm_valid),
        .output_encoded   (nrm_id),
        .output_unencoded (nrm_onehot)
    );

    irq_select sel_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .urg_valid  (urg_valid),
        .urg_id     (urg_id),
        .urg_onehot (urg_onehot),
        .nrm_valid  (nrm_valid),
        .nrm_id     (nrm_id),
        .nrm_onehot (nrm_onehot),
        .ack        (ack),
        .pend       (pend_if.sel),
        .irq        (irq),
        .irq_id     (irq_id),
        .irq_urgent (irq_urgent)
    );

endmodule

//--- verif/irq_ctrl_tb.sv
`timescale 1ns/100ps

module irq_ctrl_tb;

    logic                        clk;
    logic                        arst_n;
    logic [irq_pkg::NUM_SRC-1:0] src;
    irq_cfg_pkg::cfg_op_e        cfg_op;
    logic [irq_pkg::ID_W-1:0]    cfg_idx;
    logic                        ack;
    logic                        irq;
    logic [irq_pkg::ID_W-1:0]    irq_id;
    logic                        irq_urgent;

    // reference model of pending, mask, class and the presented interrupt
    logic [irq_pkg::NUM_SRC-1:0] m_pend;
    logic [irq_pkg::NUM_SRC-1:0] m_mask;
    logic [irq_pkg::NUM_SRC-1:0] m_cls;
    logic [irq_pkg::NUM_SRC-1:0] m_src_q;
    logic [irq_pkg::NUM_SRC-1:0] m_edges;
    logic                        m_active;
    logic [irq_pkg::ID_W-1:0]    m_id;
    logic                        m_urg;

    logic [31:0] rng;
    string       test_name;
    int          errors;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;
    // owned by the comparing process
    int          cmp_errors = 0;
    int          checks = 0;
    logic        irq_seen = 1'b0;

    irq_ctrl_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .src        (src),
        .cfg_op     (cfg_op),
        .cfg_idx    (cfg_idx),
        .ack        (ack),
        .irq        (irq),
        .irq_id     (irq_id),
        .irq_urgent (irq_urgent)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // packs {urgent, id} of the lowest unmasked urgent pending bit or else the lowest normal one
    function automatic logic [irq_pkg::ID_W:0] expect_pick(
        input logic [irq_pkg::NUM_SRC-1:0] pend,
        input logic [irq_pkg::NUM_SRC-1:0] mask,
        input logic [irq_pkg::NUM_SRC-1:0] cls
    );
        logic                     found_u;
        logic                     found_n;
        logic [irq_pkg::ID_W-1:0] id_u;
        logic [irq_pkg::ID_W-1:0] id_n;
        found_u = 1'b0;
        found_n = 1'b0;
        id_u    = '0;
        id_n    = '0;
        for (int i = 0; i < irq_pkg::NUM_SRC; i++) begin
            if (pend[i] && !mask[i] && cls[i] && !found_u) begin
                id_u    = i[irq_pkg::ID_W-1:0];
                found_u = 1'b1;
            end
            if (pend[i] && !mask[i] && !cls[i] && !found_n) begin
                id_n    = i[irq_pkg::ID_W-1:0];
                found_n = 1'b1;
            end
        end
        return found_u ? {1'b1, id_u} : {1'b0, id_n};
    endfunction

    // model follows the controller rules edge by edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_pend   = '0;
            m_mask   = '0;
            m_cls    = '0;
            m_src_q  = '0;
            m_active = 1'b0;
            m_id     = '0;
            m_urg    = 1'b0;
        end else begin
            m_edges = src & ~m_src_q;
            m_src_q = src;
            if (m_active) begin
                // ack only counts while an interrupt is presented
                if (ack) begin
                    m_pend[m_id] = 1'b0;
                    m_active     = 1'b0;
                end
            end else if ((m_pend & ~m_mask) != '0) begin
                {m_urg, m_id} = expect_pick(m_pend, m_mask, m_cls);
                m_active      = 1'b1;
            end
            // fresh edge beats a clear on the same bit
            m_pend = m_pend | m_edges;
            case (cfg_op)
                irq_cfg_pkg::CFG_SET_MASK:   m_mask[cfg_idx] = 1'b1;
                irq_cfg_pkg::CFG_CLR_MASK:   m_mask[cfg_idx] = 1'b0;
                irq_cfg_pkg::CFG_SET_URGENT: m_cls[cfg_idx]  = 1'b1;
                irq_cfg_pkg::CFG_SET_NORMAL: m_cls[cfg_idx]  = 1'b0;
                default: ;
            endcase
        end
    end

    // compare at mid cycle where the outputs have settled
    always @(negedge clk) begin
        if (arst_n) begin
            if (irq !== m_active) begin
                cmp_errors = cmp_errors + 1;
                $display("irq level %b differs from the model in test %s", irq, test_name);
            end
            if (irq && !irq_seen) begin
                checks = checks + 1;
                if (irq_id !== m_id) begin
                    cmp_errors = cmp_errors + 1;
                    $display("[ERROR] %s: irq_id expected %0d, actual %0d",
                             test_name, m_id, irq_id);
                end
                if (irq_urgent !== m_urg) begin
                    cmp_errors = cmp_errors + 1;
                    $display("[ERROR] %s: irq_urgent expected %b, actual %b",
                             test_name, m_urg, irq_urgent);
                end
            end
        end
        irq_seen = irq;
    end

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors + cmp_errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors + cmp_errors != test_err_start) begin
            tests_failed++;
            $display("test %s: FAIL", test_name);
        end else begin
            $display("test %s: pass", test_name);
        end
    endtask

    task automatic wait_irq(input int limit, output logic ok);
        irq_pkg::sel_state_e st;
        int                  n;
        n = 0;
        while (!irq && n < limit) begin
            step();
            n++;
        end
        ok = irq;
        if (!ok) begin
            st = dut_i.sel_i.state;
            errors++;
            $display("timeout in test %s: no irq within %0d cycles, selector in %s",
                     test_name, limit, st.name());
        end
    endtask

    task automatic expect_no_irq(input int cycles);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            step();
            if (irq)
                seen = 1'b1;
        end
        if (seen) begin
            errors++;
            $display("irq raised in test %s while none was expected", test_name);
        end
    endtask

    task automatic pulse_src(input logic [irq_pkg::NUM_SRC-1:0] bits);
        src = src | bits;
        step();
        src = src & ~bits;
    endtask

    task automatic cfg(input irq_cfg_pkg::cfg_op_e op, input logic [irq_pkg::ID_W-1:0] idx);
        cfg_op  = op;
        cfg_idx = idx;
        step();
        cfg_op  = irq_cfg_pkg::CFG_NOP;
    endtask

    task automatic do_ack();
        ack = 1'b1;
        step();
        ack = 1'b0;
        if (irq) begin
            errors++;
            $display("irq still high one edge after ack in test %s", test_name);
        end
    endtask

    // wait for the next interrupt, check it against the directed value, ack it
    task automatic serve(input logic [irq_pkg::ID_W-1:0] exp_id, input logic exp_urg);
        logic ok;
        wait_irq(20, ok);
        if (ok) begin
            if (irq_id !== exp_id) begin
                errors++;
                $display("[ERROR] %s: irq_id expected %0d, actual %0d", test_name, exp_id, irq_id);
            end
            if (irq_urgent !== exp_urg) begin
                errors++;
                $display("[ERROR] %s: irq_urgent expected %b, actual %b",
                         test_name, exp_urg, irq_urgent);
            end
            do_ack();
        end
    endtask

    initial begin
        logic [irq_pkg::NUM_SRC-1:0] bits;
        logic [irq_pkg::ID_W-1:0]    s;
        int                          checks_start;
        clk            = 1'b0;
        arst_n         = 1'b0;
        src            = '0;
        cfg_op         = irq_cfg_pkg::CFG_NOP;
        cfg_idx        = '0;
        ack            = 1'b0;
        rng            = 32'ha1c8_6857;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        test_name      = "reset";
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        begin_test("reset_single");
        if (irq !== 1'b0) begin
            errors++;
            $display("irq is not low after reset");
        end
        rng  = xorshift32(rng);
        s    = rng[irq_pkg::ID_W-1:0];
        bits = '0;
        bits[s] = 1'b1;
        pulse_src(bits);
        serve(s, 1'b0);
        end_test();

        // bits 0 and 7 forced so that at least two compete
        begin_test("lsb_priority");
        rng  = xorshift32(rng);
        bits = rng[irq_pkg::NUM_SRC-1:0] | 16'h0081;
        pulse_src(bits);
        for (int i = 0; i < irq_pkg::NUM_SRC; i++) begin
            if (bits[i])
                serve(i[irq_pkg::ID_W-1:0], 1'b0);
        end
        end_test();

        // source 13 urgent against normal sources 2 and 5
        begin_test("urgent_first");
        cfg(irq_cfg_pkg::CFG_SET_URGENT, 4'd13);
        pulse_src(16'h2024);
        serve(4'd13, 1'b1);
        serve(4'd2, 1'b0);
        serve(4'd5, 1'b0);
        cfg(irq_cfg_pkg::CFG_SET_NORMAL, 4'd13);
        end_test();

        begin_test("masking");
        rng  = xorshift32(rng);
        s    = rng[irq_pkg::ID_W-1:0];
        bits = '0;
        bits[s] = 1'b1;
        cfg(irq_cfg_pkg::CFG_SET_MASK, s);
        pulse_src(bits);
        expect_no_irq(8);
        // pending bit was kept while masked
        cfg(irq_cfg_pkg::CFG_CLR_MASK, s);
        serve(s, 1'b0);
        end_test();

        begin_test("edge_not_level");
        rng  = xorshift32(rng);
        s    = rng[irq_pkg::ID_W-1:0];
        bits = '0;
        bits[s] = 1'b1;
        src  = bits;
        serve(s, 1'b0);
        expect_no_irq(8);
        src = '0;
        step();
        src = bits;
        serve(s, 1'b0);
        src = '0;
        step();
        end_test();

        // sparse sources, rare config ops, acks at any time
        begin_test("random");
        checks_start = checks;
        for (int r = 0; r < 200; r++) begin
            rng  = xorshift32(rng);
            bits = '0;
            if (rng[20]) begin
                bits[rng[3:0]] = 1'b1;
                bits[rng[7:4]] = 1'b1;
            end
            src     = bits;
            cfg_idx = rng[11:8];
            cfg_op  = (rng[14:12] == 3'd0) ? irq_cfg_pkg::cfg_op_e'(rng[26:24] % 3'd5) :
                                             irq_cfg_pkg::CFG_NOP;
            ack     = rng[16] & rng[17];
            step();
        end
        src    = '0;
        cfg_op = irq_cfg_pkg::CFG_NOP;
        ack    = 1'b0;
        step();
        if (checks == checks_start) begin
            errors++;
            $display("no interrupt was presented during the random run");
        end
        end_test();

        $display("tests %0d, failed %0d, irq checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors + cmp_errors);
        if (errors + cmp_errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- irq_ctrl.f
hw/irq_pkg.sv
hw/irq_cfg_pkg.sv
hw/irq_pend_if.sv
hw/priority_encoder.sv
hw/irq_pending.sv
hw/irq_select.sv
hw/irq_ctrl_top.sv
verif/irq_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module irq_ctrl_tb \
    -f irq_ctrl.f -Mdir obj_dir -o irq_ctrl_sim

out=$(./obj_dir/irq_ctrl_sim)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
